// ==== include/ns_defines.svh ====
`ifndef NS_DEFINES_SVH
`define NS_DEFINES_SVH

// Message field widths
`define NS_ASZ 4
`define NS_DSZ 8
`define NS_RSZ 4

// Destination range the sources walk through
`define NS_MIN_ADDR 1
`define NS_MAX_ADDR 3

// Next destination wraps back to the minimum after the maximum
`define NS_NXT_ADDR(adr) \
	(((adr) >= `NS_MAX_ADDR) ? `NS_ASZ'(`NS_MIN_ADDR) : ((adr) + `NS_ASZ'(1)))

`endif

// ==== hw/ns_pkg.sv ====
`include "ns_defines.svh"

package ns_pkg;

	typedef logic [`NS_ASZ-1:0] ns_addr_t;
	typedef logic [`NS_DSZ-1:0] ns_dat_t;
	typedef logic [`NS_RSZ-1:0] ns_red_t;

	// Sticky error flags
	// bit 0 source 0, bit 1 source 1, bit 2 unknown source
	typedef logic [2:0] ns_leds_t;

	// XOR of every nibble in src, dst and dat
	function automatic ns_red_t ns_calc_redun(
		input ns_addr_t src,
		input ns_addr_t dst,
		input ns_dat_t dat
	);
		logic [2*`NS_ASZ+`NS_DSZ-1:0] all_bits;
		ns_red_t acc;
		all_bits = {src, dst, dat};
		acc = '0;
		for (int i = 0; i < (2*`NS_ASZ+`NS_DSZ)/`NS_RSZ; i++) begin
			acc = acc ^ all_bits[i*`NS_RSZ +: `NS_RSZ];
		end
		return acc;
	endfunction

endpackage

// ==== hw/msg_source.sv ====
`timescale 1ns/1ns
`include "ns_defines.svh"

module msg_source
	import ns_pkg::*;
#(
	parameter int SRC_ID = 0
) (
	input  logic     snk0_clk,
	input  logic     arst_n,
	input  logic     ack,
	output logic     req,
	output ns_addr_t src,
	output ns_addr_t dst,
	output ns_dat_t  dat,
	output ns_red_t  red
);

	typedef enum logic [2:0] {
		ST_DST,
		ST_DAT,
		ST_RED,
		ST_ARM,
		ST_WAIT
	} step_t;

	step_t      state;
	ns_addr_t   dst_nxt;
	logic [3:0] cnt;
	logic       idle;

	assign src = ns_addr_t'(SRC_ID);

	// Assembly only moves while the channel is fully idle
	assign idle = !req && !ack;

	always_ff @(posedge snk0_clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= ST_DST;
			req <= 1'b0;
			dst <= `NS_ASZ'(`NS_MIN_ADDR);
			dst_nxt <= `NS_ASZ'(`NS_MIN_ADDR);
			cnt <= 4'd0;
		end else begin
			case (state)
				ST_DST: begin
					if (idle) begin
						dst <= dst_nxt;
						dst_nxt <= `NS_NXT_ADDR(dst_nxt);
						state <= ST_DAT;
					end
				end
				ST_DAT: begin
					if (idle) begin
						state <= ST_RED;
					end
				end
				ST_RED: begin
					if (idle) begin
						state <= ST_ARM;
					end
				end
				ST_ARM: begin
					if (idle) begin
						req <= 1'b1;
						state <= ST_WAIT;
					end
				end
				ST_WAIT: begin
					// Accepted, count moves on to the next message
					if (ack) begin
						req <= 1'b0;
						cnt <= cnt + 4'd1;
						state <= ST_DST;
					end
				end
				default: begin
					state <= ST_DST;
				end
			endcase
		end
	end

	// Payload fields
	always_ff @(posedge snk0_clk) begin
		if (idle && (state == ST_DAT)) begin
			dat <= ns_dat_t'(cnt);
		end
		if (idle && (state == ST_RED)) begin
			red <= ns_calc_redun(src, dst, dat);
		end
	end

endmodule

// ==== hw/msg_merge_2to1.sv ====
`timescale 1ns/1ns
`include "ns_defines.svh"

module msg_merge_2to1
	import ns_pkg::*;
(
	input  logic     snk0_clk,
	input  logic     arst_n,

	input  logic     s0_req,
	input  ns_addr_t s0_src,
	input  ns_addr_t s0_dst,
	input  ns_dat_t  s0_dat,
	input  ns_red_t  s0_red,
	output logic     s0_ack,

	input  logic     s1_req,
	input  ns_addr_t s1_src,
	input  ns_addr_t s1_dst,
	input  ns_dat_t  s1_dat,
	input  ns_red_t  s1_red,
	output logic     s1_ack,

	output logic     o0_req,
	output ns_addr_t o0_src,
	output ns_addr_t o0_dst,
	output ns_dat_t  o0_dat,
	output ns_red_t  o0_red,
	input  logic     o0_ack
);

	typedef enum logic [1:0] {
		O_IDLE,
		O_REQ,
		O_DONE
	} out_st_t;

	out_st_t out_st;
	logic    slot_full;
	logic    last_s1;
	logic    v0;
	logic    v1;
	logic    pick1;
	logic    cap0;
	logic    cap1;
	logic    rel;

	// A side is eligible only with its previous handshake closed
	assign v0 = s0_req && !s0_ack;
	assign v1 = s1_req && !s1_ack;

	// Round robin, side 1 wins a tie unless it was served last
	assign pick1 = v1 && (!v0 || !last_s1);
	assign cap1 = !slot_full && pick1;
	assign cap0 = !slot_full && v0 && !pick1;

	// Slot frees once the outbound ack is back low
	assign rel = (out_st == O_DONE) && !o0_ack;

	always_ff @(posedge snk0_clk or negedge arst_n) begin
		if (!arst_n) begin
			s0_ack <= 1'b0;
			s1_ack <= 1'b0;
			last_s1 <= 1'b1;
		end else begin
			if (cap0) begin
				s0_ack <= 1'b1;
				last_s1 <= 1'b0;
			end else if (s0_ack && !s0_req) begin
				s0_ack <= 1'b0;
			end
			if (cap1) begin
				s1_ack <= 1'b1;
				last_s1 <= 1'b1;
			end else if (s1_ack && !s1_req) begin
				s1_ack <= 1'b0;
			end
		end
	end

	always_ff @(posedge snk0_clk or negedge arst_n) begin
		if (!arst_n) begin
			slot_full <= 1'b0;
		end else if (rel) begin
			slot_full <= 1'b0;
		end else if (cap0 || cap1) begin
			slot_full <= 1'b1;
		end
	end

	// Outbound four-phase handshake
	always_ff @(posedge snk0_clk or negedge arst_n) begin
		if (!arst_n) begin
			out_st <= O_IDLE;
			o0_req <= 1'b0;
		end else begin
			case (out_st)
				O_IDLE: begin
					if (slot_full) begin
						o0_req <= 1'b1;
						out_st <= O_REQ;
					end
				end
				O_REQ: begin
					if (o0_ack) begin
						o0_req <= 1'b0;
						out_st <= O_DONE;
					end
				end
				O_DONE: begin
					if (!o0_ack) begin
						out_st <= O_IDLE;
					end
				end
				default: begin
					out_st <= O_IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge snk0_clk) begin
		if (cap0) begin
			o0_src <= s0_src;
			o0_dst <= s0_dst;
			o0_dat <= s0_dat;
			o0_red <= s0_red;
		end else if (cap1) begin
			o0_src <= s1_src;
			o0_dst <= s1_dst;
			o0_dat <= s1_dat;
			o0_red <= s1_red;
		end
	end

endmodule

// ==== hw/msg_checker.sv ====
`timescale 1ns/1ns
`include "ns_defines.svh"

module msg_checker
	import ns_pkg::*;
(
	input  logic       snk0_clk,
	input  logic       arst_n,
	input  logic       i0_req,
	input  ns_addr_t   i0_src,
	input  ns_addr_t   i0_dst,
	input  ns_dat_t    i0_dat,
	input  ns_red_t    i0_red,
	output logic       i0_ack,
	output ns_leds_t   dbg_leds,
	output logic [3:0] dbg_disp
);

	typedef enum logic [1:0] {
		CK_CAP,
		CK_RED,
		CK_CHK,
		CK_ACK
	} ck_st_t;

	ck_st_t   state;
	ns_addr_t cap_src;
	ns_addr_t cap_dst;
	ns_dat_t  cap_dat;
	ns_red_t  cap_red;
	ns_red_t  calc_red;
	ns_dat_t  prev [2];
	logic     busy;
	logic     known;
	logic     sid;
	logic     red_bad;
	logic     seq_bad;

	assign busy = i0_req && !i0_ack;

	assign known = (cap_src == ns_addr_t'(0)) || (cap_src == ns_addr_t'(1));
	assign sid = cap_src[0];
	assign red_bad = (cap_red != calc_red);

	// 15 means no previous value yet, or the counter wrapped
	assign seq_bad = (prev[sid] != ns_dat_t'(15)) &&
		(ns_dat_t'(prev[sid] + ns_dat_t'(1)) != cap_dat);

	always_ff @(posedge snk0_clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= CK_CAP;
			i0_ack <= 1'b0;
			dbg_leds <= '0;
			dbg_disp <= 4'd0;
			prev[0] <= ns_dat_t'(15);
			prev[1] <= ns_dat_t'(15);
		end else if (busy) begin
			case (state)
				CK_CAP: begin
					state <= CK_RED;
				end
				CK_RED: begin
					state <= CK_CHK;
				end
				CK_CHK: begin
					state <= CK_ACK;
					if (!known) begin
						dbg_leds[2] <= 1'b1;
					end else if (!dbg_leds[{1'b0, sid}]) begin
						// A faulty source stays flagged and is skipped
						if (red_bad || seq_bad) begin
							dbg_leds[{1'b0, sid}] <= 1'b1;
						end else begin
							prev[sid] <= cap_dat;
						end
					end
				end
				CK_ACK: begin
					dbg_disp <= cap_dat[3:0];
					i0_ack <= 1'b1;
					state <= CK_CAP;
				end
				default: begin
					state <= CK_CAP;
				end
			endcase
		end else if (!i0_req && i0_ack) begin
			i0_ack <= 1'b0;
		end
	end

	// Captured message and recomputed redundancy
	always_ff @(posedge snk0_clk) begin
		if (busy && (state == CK_CAP)) begin
			cap_src <= i0_src;
			cap_dst <= i0_dst;
			cap_dat <= i0_dat;
			cap_red <= i0_red;
		end
		if (busy && (state == CK_RED)) begin
			calc_red <= ns_calc_redun(cap_src, cap_dst, cap_dat);
		end
	end

endmodule

// ==== hw/io_2to1.sv ====
`timescale 1ns/1ns
`include "ns_defines.svh"

module io_2to1
	import ns_pkg::*;
(
	input  logic       snk0_clk,
	input  logic       arst_n,

	output logic       o0_req,
	output ns_addr_t   o0_src,
	output ns_addr_t   o0_dst,
	output ns_dat_t    o0_dat,
	output ns_red_t    o0_red,
	input  logic       o0_ack,

	input  logic       i0_req,
	input  ns_addr_t   i0_src,
	input  ns_addr_t   i0_dst,
	input  ns_dat_t    i0_dat,
	input  ns_red_t    i0_red,
	output logic       i0_ack,

	output ns_leds_t   dbg_leds,
	output logic [3:0] dbg_disp
);

	logic     s0_req;
	ns_addr_t s0_src;
	ns_addr_t s0_dst;
	ns_dat_t  s0_dat;
	ns_red_t  s0_red;
	logic     s0_ack;

	logic     s1_req;
	ns_addr_t s1_src;
	ns_addr_t s1_dst;
	ns_dat_t  s1_dat;
	ns_red_t  s1_red;
	logic     s1_ack;

	msg_source #(
		.SRC_ID(0)
	) u_src0 (
		.snk0_clk(snk0_clk),
		.arst_n(arst_n),
		.ack(s0_ack),
		.req(s0_req),
		.src(s0_src),
		.dst(s0_dst),
		.dat(s0_dat),
		.red(s0_red)
	);

	msg_source #(
		.SRC_ID(1)
	) u_src1 (
		.snk0_clk(snk0_clk),
		.arst_n(arst_n),
		.ack(s1_ack),
		.req(s1_req),
		.src(s1_src),
		.dst(s1_dst),
		.dat(s1_dat),
		.red(s1_red)
	);

	// Both sources share the single outbound channel
	msg_merge_2to1 u_merge (
		.snk0_clk(snk0_clk),
		.arst_n(arst_n),
		.s0_req(s0_req),
		.s0_src(s0_src),
		.s0_dst(s0_dst),
		.s0_dat(s0_dat),
		.s0_red(s0_red),
		.s0_ack(s0_ack),
		.s1_req(s1_req),
		.s1_src(s1_src),
		.s1_dst(s1_dst),
		.s1_dat(s1_dat),
		.s1_red(s1_red),
		.s1_ack(s1_ack),
		.o0_req(o0_req),
		.o0_src(o0_src),
		.o0_dst(o0_dst),
		.o0_dat(o0_dat),
		.o0_red(o0_red),
		.o0_ack(o0_ack)
	);

	msg_checker u_chk (
		.snk0_clk(snk0_clk),
		.arst_n(arst_n),
		.i0_req(i0_req),
		.i0_src(i0_src),
		.i0_dst(i0_dst),
		.i0_dat(i0_dat),
		.i0_red(i0_red),
		.i0_ack(i0_ack),
		.dbg_leds(dbg_leds),
		.dbg_disp(dbg_disp)
	);

endmodule

// ==== tests/io_2to1_checker.sv ====
`timescale 1ns/1ns

module io_2to1_checker
	import ns_pkg::*;
(
	input logic     snk0_clk,
	input logic     arst_n,
	input logic     o0_req,
	input ns_addr_t o0_src,
	input ns_addr_t o0_dst,
	input ns_dat_t  o0_dat,
	input ns_red_t  o0_red,
	input logic     o0_ack,
	input logic     i0_req,
	input logic     i0_ack,
	input ns_leds_t dbg_leds
);

	// Outbound request holds with stable fields until acknowledged
	a_o0_hold: assert property (@(posedge snk0_clk) disable iff (!arst_n)
		(o0_req && !o0_ack) |=> (o0_req && $stable(o0_src) && $stable(o0_dst) &&
		$stable(o0_dat) && $stable(o0_red)))
		else $error("o0 request dropped or changed before o0_ack");

	a_i0_ack: assert property (@(posedge snk0_clk) disable iff (!arst_n)
		(!i0_req && !i0_ack) |=> !i0_ack)
		else $error("i0_ack rose without i0_req");

	// Sticky flags
	a_leds_sticky: assert property (@(posedge snk0_clk) disable iff (!arst_n)
		(dbg_leds & $past(dbg_leds)) == $past(dbg_leds))
		else $error("dbg_leds cleared outside reset");

endmodule

bind io_2to1 io_2to1_checker u_hs_chk (
	.snk0_clk(snk0_clk),
	.arst_n(arst_n),
	.o0_req(o0_req),
	.o0_src(o0_src),
	.o0_dst(o0_dst),
	.o0_dat(o0_dat),
	.o0_red(o0_red),
	.o0_ack(o0_ack),
	.i0_req(i0_req),
	.i0_ack(i0_ack),
	.dbg_leds(dbg_leds)
);

// ==== tests/io_2to1_tb.sv ====
`timescale 1ns/1ns
`include "ns_defines.svh"

module io_2to1_tb
	import ns_pkg::*;
();

	typedef struct packed {
		ns_addr_t   src;
		ns_dat_t    dat;
		logic       red_ok;
		ns_leds_t   leds;
		logic [3:0] disp;
	} stim_t;

	localparam int TBL_LEN = 13;
	localparam int OUT_MSGS = 48;
	localparam int CYCLE_LIMIT = TBL_LEN * 16 + 2000;
	localparam ns_addr_t IN_DST = 4'd2;

	// src, dat, good redundancy, expected leds, expected display
	stim_t stim_tbl [TBL_LEN] = '{
		'{4'd0, 8'd0, 1'b1, 3'b000, 4'd0},
		'{4'd1, 8'd5, 1'b1, 3'b000, 4'd5},
		'{4'd0, 8'd1, 1'b1, 3'b000, 4'd1},
		'{4'd1, 8'd6, 1'b1, 3'b000, 4'd6},
		'{4'd0, 8'd2, 1'b1, 3'b000, 4'd2},
		'{4'd1, 8'd7, 1'b0, 3'b010, 4'd7},
		'{4'd0, 8'd3, 1'b1, 3'b010, 4'd3},
		'{4'd1, 8'd8, 1'b1, 3'b010, 4'd8},
		'{4'd0, 8'd4, 1'b1, 3'b010, 4'd4},
		'{4'd0, 8'd6, 1'b1, 3'b011, 4'd6},
		'{4'd2, 8'd9, 1'b1, 3'b111, 4'd9},
		'{4'd0, 8'd7, 1'b1, 3'b111, 4'd7},
		'{4'd1, 8'd9, 1'b1, 3'b111, 4'd9}
	};

	logic       snk0_clk;
	logic       arst_n;
	logic       o0_req;
	ns_addr_t   o0_src;
	ns_addr_t   o0_dst;
	ns_dat_t    o0_dat;
	ns_red_t    o0_red;
	logic       o0_ack;
	logic       i0_req;
	ns_addr_t   i0_src;
	ns_addr_t   i0_dst;
	ns_dat_t    i0_dat;
	ns_red_t    i0_red;
	logic       i0_ack;
	ns_leds_t   dbg_leds;
	logic [3:0] dbg_disp;

	logic [31:0] lfsr_state;
	logic [3:0]  exp_cnt [2];
	ns_addr_t    exp_dst [2];
	int          seen [2];
	logic        out_done;
	int          cycles;

	io_2to1 uut (
		.snk0_clk(snk0_clk),
		.arst_n(arst_n),
		.o0_req(o0_req),
		.o0_src(o0_src),
		.o0_dst(o0_dst),
		.o0_dat(o0_dat),
		.o0_red(o0_red),
		.o0_ack(o0_ack),
		.i0_req(i0_req),
		.i0_src(i0_src),
		.i0_dst(i0_dst),
		.i0_dat(i0_dat),
		.i0_red(i0_red),
		.i0_ack(i0_ack),
		.dbg_leds(dbg_leds),
		.dbg_disp(dbg_disp)
	);

	initial begin
		snk0_clk = 1'b0;
		forever begin
			#20 snk0_clk = ~snk0_clk;
		end
	end

	// XOR of the nibbles of src, dst and dat
	function automatic ns_red_t redundancy_of(input ns_addr_t s, input ns_addr_t d,
		input ns_dat_t x);
		return s ^ d ^ x[3:0] ^ x[7:4];
	endfunction

	function automatic ns_addr_t next_dst(input ns_addr_t d);
		return (d == 4'(`NS_MAX_ADDR)) ? 4'(`NS_MIN_ADDR) : d + 4'd1;
	endfunction

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	// Three LFSR bits give a delay of 0 to 7 cycles
	task automatic draw_delay(output int d);
		d = 0;
		for (int i = 0; i < 3; i++) begin
			lfsr_state = lfsr_step(lfsr_state);
			d = (d << 1) | int'(lfsr_state[0]);
		end
	endtask

	task automatic abort_run();
		$display("Checks failed");
		$fatal(1, "Stopped at the first failure");
	endtask

	task automatic report_mismatch(input string name, input logic [31:0] got,
		input logic [31:0] want);
		$display("Error at %0t ns: %s is %0h, expected %0h", $time, name, got, want);
		abort_run();
	endtask

	task automatic check_level(input string name, input logic got, input logic want);
		if (got !== want) begin
			report_mismatch(name, 32'(got), 32'(want));
		end
	endtask

	task automatic check_msg(input ns_addr_t want_dst, input ns_dat_t want_dat,
		input ns_red_t want_red);
		if (o0_dst !== want_dst) begin
			report_mismatch("o0_dst", 32'(o0_dst), 32'(want_dst));
		end else if (o0_dat !== want_dat) begin
			report_mismatch("o0_dat", 32'(o0_dat), 32'(want_dat));
		end else if (o0_red !== want_red) begin
			report_mismatch("o0_red", 32'(o0_red), 32'(want_red));
		end
	endtask

	task automatic check_leds(input ns_leds_t want);
		if (dbg_leds !== want) begin
			report_mismatch("dbg_leds", 32'(dbg_leds), 32'(want));
		end
	endtask

	task automatic check_disp(input logic [3:0] want);
		if (dbg_disp !== want) begin
			report_mismatch("dbg_disp", 32'(dbg_disp), 32'(want));
		end
	endtask

	// One full four-phase handshake on the inbound channel
	task automatic apply_entry(input int idx);
		stim_t   e;
		ns_red_t good;
		e = stim_tbl[idx];
		good = redundancy_of(e.src, IN_DST, e.dat);
		i0_src = e.src;
		i0_dst = IN_DST;
		i0_dat = e.dat;
		i0_red = e.red_ok ? good : (good ^ 4'h6);
		i0_req = 1'b1;
		@(negedge snk0_clk);
		while (!i0_ack) @(negedge snk0_clk);
		check_leds(e.leds);
		check_disp(e.disp);
		i0_req = 1'b0;
		@(negedge snk0_clk);
		while (i0_ack) @(negedge snk0_clk);
	endtask

	initial begin : main_flow
		arst_n = 1'b0;
		o0_ack = 1'b0;
		i0_req = 1'b0;
		i0_src = '0;
		i0_dst = '0;
		i0_dat = '0;
		i0_red = '0;
		lfsr_state = 32'heaea;
		out_done = 1'b0;
		repeat (8) @(posedge snk0_clk);
		@(negedge snk0_clk);
		arst_n = 1'b1;
		check_level("o0_req", o0_req, 1'b0);
		check_level("i0_ack", i0_ack, 1'b0);
		check_leds(3'b000);
		check_disp(4'd0);
		for (int i = 0; i < TBL_LEN; i++) begin
			apply_entry(i);
		end
		wait (out_done);
		@(negedge snk0_clk);
		if (seen[0] > 0 && seen[1] > 0) begin
			$display("All checks passed");
			$finish;
		end else begin
			$display("Outbound stream did not carry messages from both sources");
			abort_run();
		end
	end

	// Outbound sink with random back-pressure
	initial begin : outbound_sink
		int       delay;
		ns_addr_t sid;
		ns_dat_t  want_dat;
		for (int s = 0; s < 2; s++) begin
			exp_cnt[s] = 4'd0;
			exp_dst[s] = 4'(`NS_MIN_ADDR);
			seen[s] = 0;
		end
		wait (arst_n);
		for (int n = 0; n < OUT_MSGS; n++) begin
			while (!o0_req) @(negedge snk0_clk);
			draw_delay(delay);
			repeat (delay) @(negedge snk0_clk);
			sid = o0_src;
			if (sid > 4'd1) begin
				$display("Outbound message carries unknown source id %0d", sid);
				abort_run();
			end
			want_dat = {4'h0, exp_cnt[sid[0]]};
			check_msg(exp_dst[sid[0]], want_dat,
				redundancy_of(sid, exp_dst[sid[0]], want_dat));
			exp_cnt[sid[0]] = exp_cnt[sid[0]] + 4'd1;
			exp_dst[sid[0]] = next_dst(exp_dst[sid[0]]);
			seen[sid[0]]++;
			o0_ack = 1'b1;
			while (o0_req) @(negedge snk0_clk);
			o0_ack = 1'b0;
		end
		out_done = 1'b1;
	end

	initial begin : watchdog
		cycles = 0;
		while (cycles < CYCLE_LIMIT) begin
			@(posedge snk0_clk);
			cycles++;
		end
		$display("Timeout after %0d clock cycles without finishing", CYCLE_LIMIT);
		abort_run();
	end

endmodule

// ==== files.f ====
+incdir+include
hw/ns_pkg.sv
hw/msg_source.sv
hw/msg_merge_2to1.sv
hw/msg_checker.sv
hw/io_2to1.sv
tests/io_2to1_checker.sv
tests/io_2to1_tb.sv

// ==== Makefile ====
TOP = io_2to1_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f files.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f files.f --top-module $(TOP) -o sim_bin
	out=$$(./obj_dir/sim_bin 2>&1); echo "$$out"; \
	echo "$$out" | grep -q "All checks passed"

clean:
	rm -rf obj_dir
